// ==== Bender.yml ====
package:
  name: huf_tree_builder

sources:
  - files:
      - rtl/huf_pkg.sv
      - rtl/huf_build_ctrl.sv
      - rtl/huf_freq_scaler.sv
      - rtl/huf_merge_engine.sv
      - rtl/huf_depth_tracker.sv
      - rtl/huf_tree_builder.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tests/huf_tree_builder_tb.sv

// ==== rtl/huf_build_ctrl.sv ====
`default_nettype none

module huf_build_ctrl #(
  parameter int NUM_SYM = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  huf_pkg::pipe_eob_e    eob_in,
  input  huf_pkg::idx_t         sym_first,
  input  logic                  last_merge,
  input  logic                  over_limit,
  input  huf_pkg::rebuild_cnt_t rebuild_limit,
  input  logic                  out_not_ready,
  output logic                  reload,
  output logic                  merge_en,
  output huf_pkg::rebuild_cnt_t rebuild_cnt,
  output logic                  busy,
  output logic                  zero_symbols,
  output logic                  build_error,
  output huf_pkg::pipe_eob_e    eob_out
);

  huf_pkg::build_state_e state;
  huf_pkg::build_state_e state_nxt;
  huf_pkg::pipe_eob_e    eob_tag;   // tag returned with the result
  logic                  start;
  logic                  done;
  logic                  fail;

  assign start    = (eob_in != huf_pkg::MIDDLE) && (state == huf_pkg::IDLE);
  assign busy     = (state != huf_pkg::IDLE);
  assign reload   = (state == huf_pkg::REBUILD);
  assign merge_en = (state == huf_pkg::BUILD) && !zero_symbols;

  always_comb
  begin
    state_nxt = state;
    done      = 1'b0;
    fail      = 1'b0;
    case (state)
      huf_pkg::IDLE:
        if (start)
          state_nxt = huf_pkg::BUILD;
      huf_pkg::BUILD:
        if (zero_symbols)
          done = 1'b1;
        else if (last_merge)
          state_nxt = huf_pkg::PIPE_WAIT;
      huf_pkg::PIPE_WAIT:
        state_nxt = huf_pkg::CHECK;   // last merge event still reaching the tracker
      huf_pkg::CHECK:
        if (!over_limit)
          done = 1'b1;
        else if (rebuild_cnt >= rebuild_limit)
        begin
          done = 1'b1;
          fail = 1'b1;
        end
        else
          state_nxt = huf_pkg::REBUILD;
      huf_pkg::REBUILD:
        state_nxt = huf_pkg::BUILD;
      huf_pkg::STALL,
      huf_pkg::STALL_FAIL:
        if (!out_not_ready)
          state_nxt = huf_pkg::IDLE;
      default:
        state_nxt = huf_pkg::IDLE;
    endcase
    if (done)
    begin
      if (!out_not_ready)
        state_nxt = huf_pkg::IDLE;
      else if (fail)
        state_nxt = huf_pkg::STALL_FAIL;
      else
        state_nxt = huf_pkg::STALL;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= huf_pkg::IDLE;
      eob_tag      <= huf_pkg::MIDDLE;
      eob_out      <= huf_pkg::MIDDLE;
      rebuild_cnt  <= '0;
      zero_symbols <= 1'b0;
      build_error  <= 1'b0;
    end
    else
    begin
      state   <= state_nxt;
      eob_out <= (busy && state_nxt == huf_pkg::IDLE) ? eob_tag : huf_pkg::MIDDLE;
      if (start)
      begin
        eob_tag      <= eob_in;
        rebuild_cnt  <= '0;
        zero_symbols <= (sym_first >= huf_pkg::idx_t'(NUM_SYM));
        build_error  <= 1'b0;
      end
      else
      begin
        if (state_nxt == huf_pkg::REBUILD)
          rebuild_cnt <= rebuild_cnt + 1'b1;
        if (state_nxt == huf_pkg::IDLE && (fail || state == huf_pkg::STALL_FAIL))
          build_error <= 1'b1;
      end
    end
  end

  // result tag is a single-cycle strobe, even across back-pressure
  a_eob_single: assert property (@(posedge clk) disable iff (!rst_n)
    eob_out != huf_pkg::MIDDLE |=> eob_out == huf_pkg::MIDDLE);

  // no merge past the last table row
  a_merge_stops: assert property (@(posedge clk) disable iff (!rst_n)
    merge_en && last_merge |=> !merge_en);

endmodule

`default_nettype wire

// ==== rtl/huf_depth_tracker.sv ====
`default_nettype none

module huf_depth_tracker #(
  parameter int NUM_SYM = 16
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  huf_pkg::pipe_eob_e             eob_in,
  input  logic                           reload,
  input  logic                           merge_valid,
  input  logic                           merge_a_node,
  input  huf_pkg::idx_t                  merge_a_id,
  input  logic                           merge_b_valid,
  input  logic                           merge_b_node,
  input  huf_pkg::idx_t                  merge_b_id,
  input  huf_pkg::idx_t                  merge_id,
  input  huf_pkg::depth_t                max_code_length,
  output huf_pkg::depth_t [NUM_SYM-1:0]  sym_depth,
  output logic                           over_limit
);

  logic [NUM_SYM-1:0] in_tree;
  huf_pkg::idx_t      node_of [NUM_SYM];   // node each symbol currently hangs under
  logic [NUM_SYM-1:0] hit_leaf;
  logic [NUM_SYM-1:0] hit_node;
  logic [NUM_SYM-1:0] too_deep;
  logic               clear;

  assign clear      = (eob_in != huf_pkg::MIDDLE) || reload;
  assign over_limit = |too_deep;

  always_comb
  begin
    for (int i = 0; i < NUM_SYM; i++)
    begin
      hit_leaf[i] = (!merge_a_node && merge_a_id == huf_pkg::idx_t'(i))
                 || (merge_b_valid && !merge_b_node && merge_b_id == huf_pkg::idx_t'(i));
      hit_node[i] = in_tree[i]
                 && ((merge_a_node && node_of[i] == merge_a_id)
                  || (merge_b_valid && merge_b_node && node_of[i] == merge_b_id));
      too_deep[i] = (sym_depth[i] > max_code_length);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      in_tree   <= '0;
      sym_depth <= '0;
    end
    else if (clear)
    begin
      in_tree   <= '0;
      sym_depth <= '0;
    end
    else if (merge_valid)
    begin
      for (int i = 0; i < NUM_SYM; i++)
      begin
        if (hit_leaf[i])
        begin
          in_tree[i]   <= 1'b1;
          sym_depth[i] <= huf_pkg::depth_t'(1);
        end
        else if (hit_node[i] && !(&sym_depth[i]))   // saturates at the top code
          sym_depth[i] <= sym_depth[i] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < NUM_SYM; i++)
      if (merge_valid && (hit_leaf[i] || hit_node[i]))
        node_of[i] <= merge_id;
  end

endmodule

`default_nettype wire

// ==== rtl/huf_freq_scaler.sv ====
`default_nettype none

module huf_freq_scaler #(
  parameter int NUM_SYM = 16
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  huf_pkg::pipe_eob_e             eob_in,
  input  huf_pkg::freq_t [NUM_SYM-1:0]   sym_freq,
  input  huf_pkg::rebuild_cnt_t          rebuild_cnt,
  output huf_pkg::freq_t [NUM_SYM-1:0]   scaled_freq
);

  huf_pkg::freq_t [NUM_SYM-1:0] orig_freq;   // list as it arrived with start
  huf_pkg::freq_t [NUM_SYM-1:0] shifted;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      orig_freq <= '0;
    else if (eob_in != huf_pkg::MIDDLE)
      orig_freq <= sym_freq;
  end

  // a used symbol never drops to zero, so ascending order survives the shift
  always_comb
  begin
    for (int i = 0; i < NUM_SYM; i++)
    begin
      shifted[i] = orig_freq[i] >> rebuild_cnt;
      if (orig_freq[i] != '0 && shifted[i] == '0)
        scaled_freq[i] = huf_pkg::freq_t'(1);
      else
        scaled_freq[i] = shifted[i];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/huf_merge_engine.sv ====
`default_nettype none

module huf_merge_engine #(
  parameter int NUM_SYM = 16
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  huf_pkg::pipe_eob_e             eob_in,
  input  huf_pkg::freq_t [NUM_SYM-1:0]   sym_freq,
  input  huf_pkg::idx_t                  sym_first,
  input  huf_pkg::freq_t [NUM_SYM-1:0]   scaled_freq,
  input  logic                           reload,
  input  logic                           merge_en,
  output logic                           merge_valid,
  output logic                           merge_a_node,
  output huf_pkg::idx_t                  merge_a_id,
  output logic                           merge_b_valid,
  output logic                           merge_b_node,
  output huf_pkg::idx_t                  merge_b_id,
  output huf_pkg::idx_t                  merge_id,
  output logic                           last_merge
);

  logic                       tab_node [NUM_SYM];
  huf_pkg::idx_t              tab_id   [NUM_SYM];
  huf_pkg::freq_t             tab_w    [NUM_SYM];
  logic                       nxt_node [NUM_SYM];
  huf_pkg::idx_t              nxt_id   [NUM_SYM];
  huf_pkg::freq_t             nxt_w    [NUM_SYM];
  huf_pkg::idx_t              row_ptr;
  huf_pkg::idx_t              first_row;   // kept for rebuilds
  logic                       start;
  logic                       a_node;
  logic                       b_node;
  logic                       b_ok;
  huf_pkg::idx_t              a_id;
  huf_pkg::idx_t              b_id;
  huf_pkg::freq_t             a_w;
  huf_pkg::freq_t             b_w;
  huf_pkg::freq_t             sum_w;
  logic [huf_pkg::FREQ_W:0]   sum_full;

  assign start      = (eob_in != huf_pkg::MIDDLE);
  assign last_merge = (row_ptr >= huf_pkg::idx_t'(NUM_SYM - 2));
  assign b_ok       = (int'(row_ptr) + 1 < NUM_SYM);
  assign sum_full   = {1'b0, a_w} + {1'b0, b_w};
  assign sum_w      = sum_full[huf_pkg::FREQ_W] ? '1 : sum_full[huf_pkg::FREQ_W-1:0];

  // pick the two lowest entries
  always_comb
  begin
    a_node = 1'b0;
    a_id   = '0;
    a_w    = '0;
    b_node = 1'b0;
    b_id   = '0;
    b_w    = '0;
    for (int i = 0; i < NUM_SYM; i++)
    begin
      if (i == int'(row_ptr))
      begin
        a_node = tab_node[i];
        a_id   = tab_id[i];
        a_w    = tab_w[i];
      end
      if (i == int'(row_ptr) + 1)
      begin
        b_node = tab_node[i];
        b_id   = tab_id[i];
        b_w    = tab_w[i];
      end
    end
  end

  // entries no heavier than the new node slide down one slot, the node lands behind them
  always_comb
  begin
    for (int i = 0; i < NUM_SYM; i++)
    begin
      nxt_node[i] = tab_node[i];
      nxt_id[i]   = tab_id[i];
      nxt_w[i]    = tab_w[i];
      if (i < NUM_SYM - 1 && i > int'(row_ptr) && tab_w[i+1] <= sum_w)
      begin
        nxt_node[i] = tab_node[i+1];
        nxt_id[i]   = tab_id[i+1];
        nxt_w[i]    = tab_w[i+1];
      end
      else if (i == int'(row_ptr) + 1 || (i > int'(row_ptr) + 1 && tab_w[i] <= sum_w))
      begin
        nxt_node[i] = 1'b1;
        nxt_id[i]   = row_ptr;   // node named after the row it was built in
        nxt_w[i]    = sum_w;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < NUM_SYM; i++)
    begin
      if (start || reload)
      begin
        tab_node[i] <= 1'b0;
        tab_id[i]   <= huf_pkg::idx_t'(i);
        tab_w[i]    <= start ? sym_freq[i] : scaled_freq[i];
      end
      else if (merge_en)
      begin
        tab_node[i] <= nxt_node[i];
        tab_id[i]   <= nxt_id[i];
        tab_w[i]    <= nxt_w[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      row_ptr     <= huf_pkg::idx_t'(NUM_SYM);
      first_row   <= huf_pkg::idx_t'(NUM_SYM);
      merge_valid <= 1'b0;
    end
    else
    begin
      merge_valid <= merge_en;
      if (start)
      begin
        row_ptr   <= sym_first;
        first_row <= sym_first;
      end
      else if (reload)
        row_ptr <= first_row;
      else if (merge_en)
        row_ptr <= row_ptr + 1'b1;
    end
  end

  // merge event, qualified by merge_valid
  always_ff @(posedge clk)
  begin
    if (merge_en)
    begin
      merge_a_node  <= a_node;
      merge_a_id    <= a_id;
      merge_b_valid <= b_ok;   // low for a lone symbol
      merge_b_node  <= b_node;
      merge_b_id    <= b_id;
      merge_id      <= row_ptr;
    end
  end

  for (genvar i = 0; i < NUM_SYM - 1; i++)
  begin : g_sorted
    a_sorted: assert property (@(posedge clk) disable iff (!rst_n)
      (i >= int'(row_ptr)) |-> (tab_w[i] <= tab_w[i+1]));
  end

endmodule

`default_nettype wire

// ==== rtl/huf_pkg.sv ====
`default_nettype none

package huf_pkg;

  localparam int FREQ_W = 12;
  localparam int CL_W   = 4;
  localparam int IDX_W  = 6;   // 32 symbols plus internal node ids
  localparam int RB_W   = 4;

  typedef logic [FREQ_W-1:0] freq_t;
  typedef logic [CL_W-1:0]   depth_t;
  typedef logic [IDX_W-1:0]  idx_t;
  typedef logic [RB_W-1:0]   rebuild_cnt_t;

  // MIDDLE doubles as "no strobe"
  typedef enum logic [1:0] {
    MIDDLE     = 2'd0,
    END_BLOCK  = 2'd1,
    END_STREAM = 2'd2
  } pipe_eob_e;

  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    BUILD      = 3'd1,
    PIPE_WAIT  = 3'd2,
    CHECK      = 3'd3,
    REBUILD    = 3'd4,
    STALL      = 3'd5,
    STALL_FAIL = 3'd6
  } build_state_e;

endpackage

`default_nettype wire

// ==== rtl/huf_tree_builder.sv ====
`default_nettype none

module huf_tree_builder #(
  parameter int NUM_SYM = 16
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  huf_pkg::freq_t [NUM_SYM-1:0]   sym_freq,
  input  huf_pkg::idx_t                  sym_first,
  input  huf_pkg::pipe_eob_e             eob_in,
  input  huf_pkg::depth_t                max_code_length,
  input  huf_pkg::rebuild_cnt_t          rebuild_limit,
  input  logic                           out_not_ready,
  output logic                           busy,
  output huf_pkg::depth_t [NUM_SYM-1:0]  sym_depth,
  output logic                           zero_symbols,
  output logic                           build_error,
  output huf_pkg::pipe_eob_e             eob_out
);

  logic                         reload;
  logic                         merge_en;
  huf_pkg::rebuild_cnt_t        rebuild_cnt;
  huf_pkg::freq_t [NUM_SYM-1:0] scaled_freq;
  logic                         merge_valid;
  logic                         merge_a_node;
  huf_pkg::idx_t                merge_a_id;
  logic                         merge_b_valid;
  logic                         merge_b_node;
  huf_pkg::idx_t                merge_b_id;
  huf_pkg::idx_t                merge_id;
  logic                         last_merge;
  logic                         over_limit;

  huf_build_ctrl #(.NUM_SYM(NUM_SYM)) u_ctrl (
    .clk, .rst_n, .eob_in, .sym_first, .last_merge, .over_limit, .rebuild_limit,
    .out_not_ready, .reload, .merge_en, .rebuild_cnt, .busy, .zero_symbols,
    .build_error, .eob_out
  );

  huf_freq_scaler #(.NUM_SYM(NUM_SYM)) u_scaler (
    .clk, .rst_n, .eob_in, .sym_freq, .rebuild_cnt, .scaled_freq
  );

  huf_merge_engine #(.NUM_SYM(NUM_SYM)) u_merge (
    .clk, .rst_n, .eob_in, .sym_freq, .sym_first, .scaled_freq, .reload, .merge_en,
    .merge_valid, .merge_a_node, .merge_a_id, .merge_b_valid, .merge_b_node,
    .merge_b_id, .merge_id, .last_merge
  );

  huf_depth_tracker #(.NUM_SYM(NUM_SYM)) u_depth (
    .clk, .rst_n, .eob_in, .reload, .merge_valid, .merge_a_node, .merge_a_id,
    .merge_b_valid, .merge_b_node, .merge_b_id, .merge_id, .max_code_length,
    .sym_depth, .over_limit
  );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
rtl/huf_pkg.sv
rtl/huf_build_ctrl.sv
rtl/huf_freq_scaler.sv
rtl/huf_merge_engine.sv
rtl/huf_depth_tracker.sv
rtl/huf_tree_builder.sv
tests/huf_tree_builder_tb.sv

// ==== include/huf_tb_model.svh ====
`ifndef HUF_TB_MODEL_SVH
`define HUF_TB_MODEL_SVH

typedef int unsigned huf_list_t [];

// depths as the hardware builds them: a new node goes behind equal weights
function automatic huf_list_t huffman_depths(huf_list_t freq);
  huf_list_t   depth;
  int unsigned w [$];
  int          g [$];
  int          grp [];
  int unsigned sum;
  int          ga;
  int          gb;
  int          pos;
  depth = new[freq.size()];
  grp = new[freq.size()];
  foreach (freq[i])
  begin
    depth[i] = 0;
    grp[i] = i;
    if (freq[i] != 0)
    begin
      w.push_back(freq[i]);
      g.push_back(i);
    end
  end
  if (w.size() == 1)
    depth[g[0]] = 1;
  for (int n = freq.size(); w.size() > 1; n++)
  begin
    sum = w.pop_front();
    ga = g.pop_front();
    sum += w.pop_front();
    gb = g.pop_front();
    foreach (grp[i])
    begin
      if (freq[i] != 0 && (grp[i] == ga || grp[i] == gb))
      begin
        grp[i] = n;
        depth[i]++;
      end
    end
    pos = 0;
    while (pos < w.size() && w[pos] <= sum)
      pos++;
    w.insert(pos, sum);
    g.insert(pos, n);
  end
  return depth;
endfunction

function automatic int unsigned weighted_cost(huf_list_t freq, huf_list_t depth);
  int unsigned cost;
  cost = 0;
  foreach (freq[i])
    cost += freq[i] * depth[i];
  return cost;
endfunction

// scaled by 2**32, a complete code sums to exactly 1 << 32
function automatic longint unsigned kraft_sum(huf_list_t depth);
  longint unsigned sum;
  sum = 0;
  foreach (depth[i])
    if (depth[i] != 0)
      sum += 64'd1 << (32 - depth[i]);
  return sum;
endfunction

function automatic int unsigned max_depth(huf_list_t depth);
  int unsigned m;
  m = 0;
  foreach (depth[i])
    if (depth[i] > m)
      m = depth[i];
  return m;
endfunction

function automatic huf_list_t scale_list(huf_list_t freq, int shift);
  huf_list_t s;
  s = new[freq.size()];
  foreach (freq[i])
  begin
    s[i] = freq[i] >> shift;
    if (freq[i] != 0 && s[i] == 0)
      s[i] = 1;
  end
  return s;
endfunction

// zeros first, then used weights in 1..max_f, ascending
function automatic huf_list_t random_sorted_list(int n, int used, int max_f, inout int seed);
  huf_list_t f;
  f = new[n];
  foreach (f[i])
    f[i] = (i < n - used) ? 0 : 1 + ($unsigned($random(seed)) % max_f);
  f.sort();
  return f;
endfunction

`endif

// ==== tests/huf_tree_builder_tb.sv ====
`default_nettype none

module huf_tree_builder_tb;

  localparam int NUM_SYM        = 16;
  localparam int NUM_TESTS      = 13;
  localparam int MAX_LIMIT      = 15;   // largest rebuild_limit any test uses
  localparam int TIMEOUT_CYCLES = NUM_TESTS * NUM_SYM * (MAX_LIMIT + 2) * 4 + 500;

`include "huf_tb_model.svh"

  logic                           clk;
  logic                           rst_n;
  huf_pkg::freq_t [NUM_SYM-1:0]   sym_freq;
  huf_pkg::idx_t                  sym_first;
  huf_pkg::pipe_eob_e             eob_in;
  huf_pkg::depth_t                max_code_length;
  huf_pkg::rebuild_cnt_t          rebuild_limit;
  logic                           out_not_ready;
  logic                           busy;
  huf_pkg::depth_t [NUM_SYM-1:0]  sym_depth;
  logic                           zero_symbols;
  logic                           build_error;
  huf_pkg::pipe_eob_e             eob_out;

  string              test_name;
  huf_pkg::pipe_eob_e exp_tag;
  logic               exp_error;
  logic               exp_zero;
  logic               check_kraft;
  int unsigned        exp_cost;
  longint unsigned    exp_kraft;
  int unsigned        cost_w [NUM_SYM];   // weights the build actually used
  int unsigned        act_cost;
  longint unsigned    act_kraft;
  int                 act_max;
  int                 act_stray;
  int                 seed;
  int                 errors;
  int                 tests_run;
  int                 tests_failed;
  int                 cycles = 0;

  huf_tree_builder #(.NUM_SYM(NUM_SYM)) u_dut (
    .clk, .rst_n, .sym_freq, .sym_first, .eob_in, .max_code_length, .rebuild_limit,
    .out_not_ready, .busy, .sym_depth, .zero_symbols, .build_error, .eob_out
  );

  always #2 clk = ~clk;

  always_comb
  begin
    act_cost  = 0;
    act_kraft = 0;
    act_max   = 0;
    act_stray = 0;
    for (int i = 0; i < NUM_SYM; i++)
    begin
      act_cost += cost_w[i] * sym_depth[i];
      if (sym_depth[i] != 0)
        act_kraft += 64'd1 << (32 - sym_depth[i]);
      if (sym_depth[i] > act_max)
        act_max = sym_depth[i];
      if (cost_w[i] == 0 && sym_depth[i] != 0)
        act_stray++;   // unused symbol got a code
    end
  end

  task automatic log_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  a_tag: assert property (@(posedge clk) disable iff (!rst_n)
    eob_out != huf_pkg::MIDDLE |-> eob_out == exp_tag)
    else log_error($sformatf("[FAIL] %s eob_out: expected %0d, actual %0d", test_name,
      $sampled(exp_tag), $sampled(eob_out)));
  a_error: assert property (@(posedge clk) disable iff (!rst_n)
    eob_out != huf_pkg::MIDDLE |-> build_error == exp_error)
    else log_error($sformatf("[FAIL] %s build_error: expected %0b, actual %0b",
      test_name, $sampled(exp_error), $sampled(build_error)));
  a_zero: assert property (@(posedge clk) disable iff (!rst_n)
    eob_out != huf_pkg::MIDDLE |-> zero_symbols == exp_zero)
    else log_error($sformatf("[FAIL] %s zero_symbols: expected %0b, actual %0b",
      test_name, $sampled(exp_zero), $sampled(zero_symbols)));
  a_cost: assert property (@(posedge clk) disable iff (!rst_n)
    eob_out != huf_pkg::MIDDLE && !exp_error |-> act_cost == exp_cost)
    else log_error($sformatf("[FAIL] %s cost: expected %0d, actual %0d", test_name,
      $sampled(exp_cost), $sampled(act_cost)));
  a_stray: assert property (@(posedge clk) disable iff (!rst_n)
    eob_out != huf_pkg::MIDDLE |-> act_stray == 0)
    else log_error($sformatf("[FAIL] %s unused depths: expected 0, actual %0d nonzero",
      test_name, $sampled(act_stray)));
  a_kraft: assert property (@(posedge clk) disable iff (!rst_n)
    eob_out != huf_pkg::MIDDLE && check_kraft |-> act_kraft == exp_kraft)
    else log_error($sformatf("[FAIL] %s kraft: expected %0h, actual %0h", test_name,
      $sampled(exp_kraft), $sampled(act_kraft)));
  a_max_len: assert property (@(posedge clk) disable iff (!rst_n)
    eob_out != huf_pkg::MIDDLE && !exp_error |-> act_max <= max_code_length)
    else log_error($sformatf("[FAIL] %s max depth: expected <= %0d, actual %0d",
      test_name, $sampled(max_code_length), $sampled(act_max)));
  a_busy_start: assert property (@(posedge clk) disable iff (!rst_n)
    eob_in != huf_pkg::MIDDLE && !busy |=> busy)
    else log_error($sformatf("%s: busy did not rise after start", test_name));
  a_empty_latency: assert property (@(posedge clk) disable iff (!rst_n)
    eob_in != huf_pkg::MIDDLE && !busy && sym_first == huf_pkg::idx_t'(NUM_SYM)
    && !out_not_ready |-> ##2 eob_out != huf_pkg::MIDDLE)
    else log_error($sformatf("%s: empty list result not 2 cycles after start",
      test_name));
  a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    out_not_ready |=> eob_out == huf_pkg::MIDDLE)
    else log_error($sformatf("%s: eob_out pulsed while receiver not ready", test_name));
  a_hold_busy: assert property (@(posedge clk) disable iff (!rst_n)
    busy && out_not_ready |=> busy)
    else log_error($sformatf("%s: busy dropped under back-pressure", test_name));
  a_release: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(out_not_ready) && busy |=> eob_out == exp_tag)
    else log_error($sformatf("[FAIL] %s released tag: expected %0d, actual %0d",
      test_name, $sampled(exp_tag), $sampled(eob_out)));

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout: no end of run after %0d cycles", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic huf_list_t fibonacci_list(int n);
    huf_list_t f;
    f = new[n];
    foreach (f[i])
      f[i] = (i < 2) ? 1 : f[i-1] + f[i-2];
    return f;
  endfunction

  // expected result comes from the first shift whose tree fits max_len
  task automatic run_build(input string name, input huf_list_t f, input int max_len,
                           input int limit, input huf_pkg::pipe_eob_e tag, input bit stall);
    huf_list_t sc;
    huf_list_t d;
    int        used;
    int        errs_before;
    bit        found;
    used        = 0;
    found       = 1'b0;
    errs_before = errors;
    foreach (f[i])
      if (f[i] != 0)
        used++;
    for (int s = 0; s <= limit && !found; s++)
    begin
      sc    = scale_list(f, s);
      d     = huffman_depths(sc);
      found = (max_depth(d) <= max_len);
    end
    @(posedge clk);
    #1;
    test_name   = name;
    exp_tag     = tag;
    exp_zero    = (used == 0);
    exp_error   = !found;
    check_kraft = found && used > 1;
    exp_cost    = weighted_cost(sc, d);
    exp_kraft   = kraft_sum(d);
    for (int i = 0; i < NUM_SYM; i++)
    begin
      cost_w[i]   = sc[i];
      sym_freq[i] = huf_pkg::freq_t'(f[i]);
    end
    sym_first       = huf_pkg::idx_t'(NUM_SYM - used);
    max_code_length = huf_pkg::depth_t'(max_len);
    rebuild_limit   = huf_pkg::rebuild_cnt_t'(limit);
    out_not_ready   = stall;
    eob_in          = tag;
    @(posedge clk);
    #1;
    eob_in = huf_pkg::MIDDLE;
    if (stall)
    begin
      repeat ((NUM_SYM + 4) * (limit + 1) + 4) @(posedge clk);   // longer than any build
      #1;
      out_not_ready = 1'b0;
    end
    while (eob_out == huf_pkg::MIDDLE)
    begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);   // result checks sample here
    #1;
    tests_run++;
    if (errors != errs_before)
      tests_failed++;
    $display("test %-16s %s", name, (errors == errs_before) ? "ok" : "failed");
  endtask

  initial
  begin
    huf_list_t f;
    int        used;
    clk             = 1'b0;
    rst_n           = 1'b0;
    sym_freq        = '0;
    sym_first       = huf_pkg::idx_t'(NUM_SYM);
    eob_in          = huf_pkg::MIDDLE;
    max_code_length = huf_pkg::depth_t'(15);
    rebuild_limit   = '0;
    out_not_ready   = 1'b0;
    test_name       = "reset";
    exp_tag         = huf_pkg::MIDDLE;
    exp_error       = 1'b0;
    exp_zero        = 1'b0;
    check_kraft     = 1'b0;
    exp_cost        = 0;
    exp_kraft       = 0;
    foreach (cost_w[i])
      cost_w[i] = 0;
    seed         = 32'h0d8b_b8b7;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int t = 0; t < 8; t++)
    begin
      used = 2 + ($unsigned($random(seed)) % (NUM_SYM - 1));
      f    = random_sorted_list(NUM_SYM, used, 200, seed);
      run_build($sformatf("random_%0d", t), f, 15, 3,
                (t % 2) ? huf_pkg::END_STREAM : huf_pkg::END_BLOCK, 1'b0);
    end
    f = random_sorted_list(NUM_SYM, 1, 100, seed);
    run_build("single_symbol", f, 15, 3, huf_pkg::END_BLOCK, 1'b0);
    run_build("fib_rescaled", fibonacci_list(NUM_SYM), 7, MAX_LIMIT, huf_pkg::END_BLOCK, 1'b0);
    run_build("rebuild_error", fibonacci_list(NUM_SYM), 5, 1, huf_pkg::END_STREAM, 1'b0);
    f = random_sorted_list(NUM_SYM, 0, 1, seed);
    run_build("empty_list", f, 15, 3, huf_pkg::END_BLOCK, 1'b0);
    f = random_sorted_list(NUM_SYM, 12, 200, seed);
    run_build("back_pressure", f, 6, 8, huf_pkg::END_STREAM, 1'b1);
    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire
